//--- hw/front_defines.svh
`ifndef FRONT_DEFINES_SVH
`define FRONT_DEFINES_SVH

// Fetch address width, counted in instruction words
`define FRONT_ADDR_W 16

// Instruction word width
`define FRONT_DATA_W 24

// First fetch address out of reset
`define FRONT_RESET_PC 16'h0000

`endif

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Opcode byte, bits 23..16 of every word
    typedef enum logic [7:0] {
        OPC_MOVur   = 8'h01,
        OPC_ADDur   = 8'h02,
        OPC_SUBur   = 8'h03,
        OPC_CMPur   = 8'h04,
        OPC_LDur    = 8'h11,
        OPC_STur    = 8'h12,
        OPC_MOVui   = 8'h21,
        OPC_ADDui   = 8'h22,
        OPC_CMPui   = 8'h23,
        OPC_STui    = 8'h24,
        OPC_ADDsi   = 8'h31,
        OPC_JCCur   = 8'h41,
        OPC_JCCui   = 8'h42,
        OPC_BALso   = 8'h51,
        OPC_SRMOVur = 8'h61,
        OPC_SRLDso  = 8'h62
    } opcode_e;

    // Register form
    // Address and special register numbers live in the nibble halves
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] tgt;
        logic [3:0] src;
        logic [7:0] spare;
    } instr_reg_t;

    // Immediate form
    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  hi;
        logic [11:0] imm12;
    } instr_imm_t;

    // Same 24-bit word, two views
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Fetch master states
    typedef enum logic [1:0] {
        FS_IDLE    = 2'd0,
        FS_REQ     = 2'd1,
        FS_DISCARD = 2'd2
    } fetch_state_e;

    // Immediate width carried with the decoded word
    typedef enum logic [1:0] {
        IMM_NONE = 2'd0,
        IMM_12   = 2'd1,
        IMM_16   = 2'd2
    } imm_kind_e;

endpackage

`default_nettype wire

//--- hw/fetch_wb.sv
`timescale 1ns/1ps
`default_nettype none
`include "front_defines.svh"

module fetch_wb import pipe_pkg::*; (
    input  wire                       iw_clk,
    input  wire                       iw_rst,
    input  wire                       stall,
    input  wire                       flush,
    input  wire  [`FRONT_ADDR_W-1:0]  redirect_pc,
    input  wire  [`FRONT_DATA_W-1:0]  wb_dat_i,
    input  wire                       wb_ack,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [`FRONT_ADDR_W-1:0]  wb_adr,
    output logic [`FRONT_ADDR_W-1:0]  fetch_pc,
    output logic [`FRONT_DATA_W-1:0]  fetch_instr,
    output logic                      fetch_valid
);
    fetch_state_e             state_q;
    logic [`FRONT_ADDR_W-1:0] pc_q;
    logic [`FRONT_ADDR_W-1:0] adr_q;
    logic                     hold_valid;
    logic [`FRONT_ADDR_W-1:0] hold_pc;
    logic [`FRONT_DATA_W-1:0] hold_instr;
    logic                     take;

    // Word arrives for decode
    assign take = (state_q == FS_REQ) && wb_ack;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state_q    <= FS_IDLE;
            pc_q       <= `FRONT_RESET_PC;
            adr_q      <= `FRONT_RESET_PC;
            hold_valid <= 1'b0;
        end else if (flush) begin
            pc_q       <= redirect_pc;
            hold_valid <= 1'b0;
            // Open transfer still has to finish on the bus
            state_q    <= (wb_cyc && !wb_ack) ? FS_DISCARD : FS_IDLE;
        end else begin
            case (state_q)
                FS_IDLE: begin
                    if (!stall) begin
                        state_q    <= FS_REQ;
                        adr_q      <= pc_q;
                        pc_q       <= pc_q + 1'b1;
                        hold_valid <= 1'b0;
                    end
                end
                FS_REQ: begin
                    if (wb_ack && !stall) begin
                        adr_q <= pc_q;
                        pc_q  <= pc_q + 1'b1;
                    end else if (wb_ack) begin
                        state_q    <= FS_IDLE;
                        hold_valid <= 1'b1;
                    end
                end
                FS_DISCARD: begin
                    if (wb_ack) begin
                        state_q <= FS_IDLE;
                    end
                end
                default: state_q <= FS_IDLE;
            endcase
        end
    end

    // Parked word while decode is stalled
    always_ff @(posedge iw_clk) begin
        if (take && stall && !flush) begin
            hold_pc    <= adr_q;
            hold_instr <= wb_dat_i;
        end
    end

    assign wb_cyc      = (state_q != FS_IDLE);
    assign wb_stb      = wb_cyc;
    assign wb_we       = 1'b0;
    assign wb_adr      = adr_q;
    assign fetch_valid = hold_valid || take;
    assign fetch_pc    = hold_valid ? hold_pc : adr_q;
    assign fetch_instr = hold_valid ? hold_instr : wb_dat_i;

    // Stalled word stays on offer
    a_hold_word: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (fetch_valid && stall && !flush) |=> (fetch_valid && $stable(fetch_pc)
                                               && $stable(fetch_instr)))
        else $error("fetch_wb: stalled word lost");

    // Request stays put until the slave answers
    a_adr_stable: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (state_q != FS_IDLE && !wb_ack) |=> (wb_cyc && $stable(wb_adr)))
        else $error("fetch_wb: address moved before ack");

endmodule

`default_nettype wire

//--- hw/imm_decode.sv
`timescale 1ns/1ps
`default_nettype none

module imm_decode import isa_pkg::*; import pipe_pkg::*; (
    input  wire instr_u  instr,
    output logic         imm_en,
    output logic         sgn_en,
    output imm_kind_e    imm_kind,
    output logic [15:0]  imm_val,
    output logic [3:0]   cc
);
    // Immediate class per opcode
    always_comb begin
        imm_kind = IMM_NONE;
        sgn_en   = 1'b0;
        case (instr.i.opcode)
            OPC_MOVui, OPC_ADDui, OPC_CMPui, OPC_STui, OPC_JCCui: begin
                imm_kind = IMM_12;
            end
            OPC_ADDsi, OPC_SRLDso: begin
                imm_kind = IMM_12;
                sgn_en   = 1'b1;
            end
            OPC_BALso: begin
                imm_kind = IMM_16;
                sgn_en   = 1'b1;
            end
            default: begin
                imm_kind = IMM_NONE;
            end
        endcase
    end

    assign imm_en = (imm_kind != IMM_NONE);

    // Widen to 16 bits
    always_comb begin
        case (imm_kind)
            IMM_12: begin
                if (sgn_en) begin
                    imm_val = {{4{instr.i.imm12[11]}}, instr.i.imm12};
                end else begin
                    imm_val = {4'h0, instr.i.imm12};
                end
            end
            IMM_16:  imm_val = {instr.i.hi, instr.i.imm12};
            default: imm_val = 16'h0000;
        endcase
    end

    // JCCur keeps its condition at 13..10, straddling tgt and src
    always_comb begin
        case (instr.r.opcode)
            OPC_JCCur: cc = {instr.r.tgt[1:0], instr.r.src[3:2]};
            OPC_JCCui: cc = instr.i.hi;
            default:   cc = 4'h0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module reg_decode import isa_pkg::*; (
    input  wire instr_u  instr,
    output logic         has_src_gp,
    output logic [3:0]   src_gp,
    output logic [3:0]   tgt_gp,
    output logic         tgt_gp_we,
    output logic         has_src_ar,
    output logic [1:0]   src_ar,
    output logic         has_tgt_ar,
    output logic [1:0]   tgt_ar,
    output logic         has_src_sr,
    output logic [1:0]   src_sr,
    output logic [1:0]   tgt_sr,
    output logic         tgt_sr_we
);
    opcode_e opc;
    logic    has_tgt_gp;

    // Two-bit register numbers sit in nibble halves
    function automatic logic [1:0] half(input logic [3:0] nib, input logic upper);
        return upper ? nib[3:2] : nib[1:0];
    endfunction

    assign opc = instr.r.opcode;

    always_comb begin
        tgt_gp_we  = 1'b0;
        has_tgt_gp = 1'b0;
        has_src_gp = 1'b0;
        has_src_ar = 1'b0;
        has_tgt_ar = 1'b0;
        tgt_sr_we  = 1'b0;
        case (opc)
            OPC_MOVur, OPC_ADDur, OPC_SUBur: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
                has_src_gp = 1'b1;
            end
            OPC_CMPur: begin
                has_tgt_gp = 1'b1;
                has_src_gp = 1'b1;
            end
            OPC_LDur: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
                has_src_gp = 1'b1;
                has_src_ar = 1'b1;
            end
            OPC_STur: begin
                has_tgt_gp = 1'b1;
                has_src_gp = 1'b1;
                has_tgt_ar = 1'b1;
            end
            OPC_MOVui, OPC_ADDui, OPC_ADDsi: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
            end
            OPC_CMPui, OPC_STui: has_tgt_gp = 1'b1;
            OPC_JCCur:           has_tgt_ar = 1'b1;
            OPC_SRMOVur, OPC_SRLDso: tgt_sr_we = 1'b1;
            default: ;
        endcase
    end

    // Both SR forms read one SR and write another
    assign has_src_sr = tgt_sr_we;

    assign tgt_gp = has_tgt_gp ? instr.r.tgt : 4'h0;
    assign src_gp = has_src_gp ? instr.r.src : 4'h0;
    assign src_ar = has_src_ar ? half(instr.r.src, 1'b1) : 2'b00;
    assign tgt_ar = has_tgt_ar ? half(instr.r.tgt, 1'b1) : 2'b00;
    assign tgt_sr = tgt_sr_we  ? half(instr.r.tgt, 1'b1) : 2'b00;
    assign src_sr = has_src_sr ? half(instr.r.tgt, 1'b0) : 2'b00;

endmodule

`default_nettype wire

//--- hw/stg_id.sv
`timescale 1ns/1ps
`default_nettype none
`include "front_defines.svh"

module stg_id import isa_pkg::*; import pipe_pkg::*; (
    input  wire                       iw_clk,
    input  wire                       iw_rst,
    input  wire                       flush,
    input  wire                       stall,
    input  wire  [`FRONT_ADDR_W-1:0]  fetch_pc,
    input  wire  [`FRONT_DATA_W-1:0]  fetch_instr,
    input  wire                       fetch_valid,
    input  wire                       imm_en,
    input  wire                       sgn_en,
    input  wire  imm_kind_e           imm_kind,
    input  wire  [15:0]               imm_val,
    input  wire  [3:0]                cc,
    input  wire                       has_src_gp,
    input  wire  [3:0]                src_gp,
    input  wire  [3:0]                tgt_gp,
    input  wire                       tgt_gp_we,
    input  wire                       has_src_ar,
    input  wire  [1:0]                src_ar,
    input  wire                       has_tgt_ar,
    input  wire  [1:0]                tgt_ar,
    input  wire                       has_src_sr,
    input  wire  [1:0]                src_sr,
    input  wire  [1:0]                tgt_sr,
    input  wire                       tgt_sr_we,
    output logic                      id_valid,
    output logic [`FRONT_ADDR_W-1:0]  id_pc,
    output logic [`FRONT_DATA_W-1:0]  id_instr,
    output opcode_e                   id_opc,
    output logic                      id_imm_en,
    output logic                      id_sgn_en,
    output imm_kind_e                 id_imm_kind,
    output logic [15:0]               id_imm_val,
    output logic [3:0]                id_cc,
    output logic                      id_has_src_gp,
    output logic [3:0]                id_src_gp,
    output logic [3:0]                id_tgt_gp,
    output logic                      id_tgt_gp_we,
    output logic                      id_has_src_ar,
    output logic [1:0]                id_src_ar,
    output logic                      id_has_tgt_ar,
    output logic [1:0]                id_tgt_ar,
    output logic                      id_has_src_sr,
    output logic [1:0]                id_src_sr,
    output logic [1:0]                id_tgt_sr,
    output logic                      id_tgt_sr_we
);
    localparam int BUNDLE_W = `FRONT_ADDR_W + `FRONT_DATA_W + 44;

    logic [BUNDLE_W-1:0] bundle_d;
    logic [BUNDLE_W-1:0] bundle_q;
    logic [1:0]          kind_q;
    instr_u              id_word;

    // Fetched word and both decoder results side by side
    assign bundle_d = {fetch_pc, fetch_instr, imm_en, sgn_en, imm_kind, imm_val, cc,
                       has_src_gp, src_gp, tgt_gp, has_src_ar, src_ar, has_tgt_ar, tgt_ar,
                       has_src_sr, src_sr, tgt_sr};

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            id_valid     <= 1'b0;
            id_tgt_gp_we <= 1'b0;
            id_tgt_sr_we <= 1'b0;
            bundle_q     <= '0;
        end else if (flush) begin
            id_valid     <= 1'b0;
            id_tgt_gp_we <= 1'b0;
            id_tgt_sr_we <= 1'b0;
            bundle_q     <= '0;
        end else if (!stall) begin
            id_valid     <= fetch_valid;
            // Bubbles never write
            id_tgt_gp_we <= tgt_gp_we && fetch_valid;
            id_tgt_sr_we <= tgt_sr_we && fetch_valid;
            bundle_q     <= fetch_valid ? bundle_d : '0;
        end
    end

    assign {id_pc, id_instr, id_imm_en, id_sgn_en, kind_q, id_imm_val, id_cc,
            id_has_src_gp, id_src_gp, id_tgt_gp, id_has_src_ar, id_src_ar, id_has_tgt_ar,
            id_tgt_ar, id_has_src_sr, id_src_sr, id_tgt_sr} = bundle_q;

    assign id_imm_kind = imm_kind_e'(kind_q);
    assign id_word     = id_instr;
    assign id_opc      = id_word.r.opcode;

endmodule

`default_nettype wire

//--- hw/front_end.sv
`timescale 1ns/1ps
`default_nettype none
`include "front_defines.svh"

module front_end import isa_pkg::*; import pipe_pkg::*; (
    input  wire                       iw_clk,
    input  wire                       iw_rst,
    input  wire                       flush,
    input  wire  [`FRONT_ADDR_W-1:0]  redirect_pc,
    input  wire                       stall,
    input  wire  [`FRONT_DATA_W-1:0]  wb_dat_i,
    input  wire                       wb_ack,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [`FRONT_ADDR_W-1:0]  wb_adr,
    output logic                      id_valid,
    output logic [`FRONT_ADDR_W-1:0]  id_pc,
    output logic [`FRONT_DATA_W-1:0]  id_instr,
    output opcode_e                   id_opc,
    output logic                      id_imm_en,
    output logic                      id_sgn_en,
    output imm_kind_e                 id_imm_kind,
    output logic [15:0]               id_imm_val,
    output logic [3:0]                id_cc,
    output logic                      id_has_src_gp,
    output logic [3:0]                id_src_gp,
    output logic [3:0]                id_tgt_gp,
    output logic                      id_tgt_gp_we,
    output logic                      id_has_src_ar,
    output logic [1:0]                id_src_ar,
    output logic                      id_has_tgt_ar,
    output logic [1:0]                id_tgt_ar,
    output logic                      id_has_src_sr,
    output logic [1:0]                id_src_sr,
    output logic [1:0]                id_tgt_sr,
    output logic                      id_tgt_sr_we
);
    logic [`FRONT_ADDR_W-1:0] fetch_pc;
    logic [`FRONT_DATA_W-1:0] fetch_instr;
    logic                     fetch_valid;
    logic                     imm_en;
    logic                     sgn_en;
    imm_kind_e                imm_kind;
    logic [15:0]              imm_val;
    logic [3:0]               cc;
    logic                     has_src_gp;
    logic [3:0]               src_gp;
    logic [3:0]               tgt_gp;
    logic                     tgt_gp_we;
    logic                     has_src_ar;
    logic [1:0]               src_ar;
    logic                     has_tgt_ar;
    logic [1:0]               tgt_ar;
    logic                     has_src_sr;
    logic [1:0]               src_sr;
    logic [1:0]               tgt_sr;
    logic                     tgt_sr_we;

    fetch_wb u_fetch (.*);

    // Both decoders look at the raw bus word
    imm_decode u_imm_dec (
        .instr (fetch_instr),
        .*
    );

    reg_decode u_reg_dec (
        .instr (fetch_instr),
        .*
    );

    stg_id u_stg_id (.*);

endmodule

`default_nettype wire

//--- test/tb_wb_imem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_imem (
    input  wire         iw_clk,
    input  wire         iw_rst,
    input  wire         cyc,
    input  wire         stb,
    input  wire         we,
    input  wire  [15:0] adr,
    output logic [23:0] dat,
    output logic        ack
);
    // Loaded by the testbench before reset is released
    logic [23:0] mem [0:255];
    logic [1:0]  wait_cnt;
    integer      seed;

    initial begin
        seed = 32'h82e2;
    end

    // Classic slave, registered ack after 0 to 3 wait cycles
    always @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ack      <= 1'b0;
            dat      <= 24'h0;
            wait_cnt <= 2'd0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !we && !ack) begin
                if (wait_cnt == 2'd0) begin
                    ack      <= 1'b1;
                    dat      <= mem[adr[7:0]];
                    wait_cnt <= $random(seed);
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_front_end.sv
`timescale 1ns/1ps
`default_nettype none
`include "front_defines.svh"

module tb_front_end;

    localparam logic [7:0] MOV_UR   = 8'h01;
    localparam logic [7:0] ADD_UR   = 8'h02;
    localparam logic [7:0] SUB_UR   = 8'h03;
    localparam logic [7:0] CMP_UR   = 8'h04;
    localparam logic [7:0] LD_UR    = 8'h11;
    localparam logic [7:0] ST_UR    = 8'h12;
    localparam logic [7:0] MOV_UI   = 8'h21;
    localparam logic [7:0] ADD_UI   = 8'h22;
    localparam logic [7:0] CMP_UI   = 8'h23;
    localparam logic [7:0] ST_UI    = 8'h24;
    localparam logic [7:0] ADD_SI   = 8'h31;
    localparam logic [7:0] JCC_UR   = 8'h41;
    localparam logic [7:0] JCC_UI   = 8'h42;
    localparam logic [7:0] BAL_SO   = 8'h51;
    localparam logic [7:0] SRMOV_UR = 8'h61;
    localparam logic [7:0] SRLD_SO  = 8'h62;

    typedef struct packed {
        logic        imm_en;
        logic        sgn_en;
        logic [1:0]  kind;
        logic [15:0] imm_val;
        logic [3:0]  cc;
        logic        has_src_gp;
        logic [3:0]  src_gp;
        logic [3:0]  tgt_gp;
        logic        gp_we;
        logic        has_src_ar;
        logic [1:0]  src_ar;
        logic        has_tgt_ar;
        logic [1:0]  tgt_ar;
        logic        has_src_sr;
        logic [1:0]  src_sr;
        logic [1:0]  tgt_sr;
        logic        sr_we;
    } ref_t;

    logic                     iw_clk;
    logic                     iw_rst;
    logic                     flush;
    logic                     stall;
    logic [`FRONT_ADDR_W-1:0] redirect_pc;
    logic [`FRONT_DATA_W-1:0] wb_dat_i;
    logic                     wb_ack;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`FRONT_ADDR_W-1:0] wb_adr;
    logic                     id_valid;
    logic [`FRONT_ADDR_W-1:0] id_pc;
    logic [`FRONT_DATA_W-1:0] id_instr;
    logic [7:0]               id_opc;
    logic                     id_imm_en;
    logic                     id_sgn_en;
    logic [1:0]               id_imm_kind;
    logic [15:0]              id_imm_val;
    logic [3:0]               id_cc;
    logic                     id_has_src_gp;
    logic [3:0]               id_src_gp;
    logic [3:0]               id_tgt_gp;
    logic                     id_tgt_gp_we;
    logic                     id_has_src_ar;
    logic [1:0]               id_src_ar;
    logic                     id_has_tgt_ar;
    logic [1:0]               id_tgt_ar;
    logic                     id_has_src_sr;
    logic [1:0]               id_src_sr;
    logic [1:0]               id_tgt_sr;
    logic                     id_tgt_sr_we;

    logic [23:0]              prog [0:255];
    logic [7:0]               opc_list [0:15];
    integer                   seed;
    logic                     stall_prev;
    logic                     discard_pending;
    logic                     seen_ack;
    logic                     seen_req;
    logic [`FRONT_ADDR_W-1:0] next_pc;
    integer                   n_fresh;
    integer                   n_discard;
    logic                     fresh;
    logic [23:0]              exp_word;
    ref_t                     exp_dec;

    front_end dut0 (.*);

    tb_wb_imem imem0 (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .cyc    (wb_cyc),
        .stb    (wb_stb),
        .we     (wb_we),
        .adr    (wb_adr),
        .dat    (wb_dat_i),
        .ack    (wb_ack)
    );

    initial begin
        iw_clk = 1'b0;
    end

    always #4 iw_clk = ~iw_clk;

    function automatic ref_t ref_decode(input logic [23:0] w);
        ref_t       r;
        logic [7:0] op;
        r  = '0;
        op = w[23:16];
        case (op)
            MOV_UI, ADD_UI, CMP_UI, ST_UI, JCC_UI: begin
                r.kind    = 2'd1;
                r.imm_val = {4'h0, w[11:0]};
            end
            ADD_SI, SRLD_SO: begin
                r.kind    = 2'd1;
                r.sgn_en  = 1'b1;
                r.imm_val = {{4{w[11]}}, w[11:0]};
            end
            BAL_SO: begin
                r.kind    = 2'd2;
                r.sgn_en  = 1'b1;
                r.imm_val = w[15:0];
            end
            default: r.kind = 2'd0;
        endcase
        r.imm_en = (r.kind != 2'd0);
        if (op == JCC_UR) r.cc = w[13:10];
        if (op == JCC_UI) r.cc = w[15:12];
        if (op inside {MOV_UR, ADD_UR, SUB_UR, CMP_UR, LD_UR, ST_UR,
                       MOV_UI, ADD_UI, ADD_SI, CMP_UI, ST_UI}) begin
            r.tgt_gp = w[15:12];
        end
        if (op inside {MOV_UR, ADD_UR, SUB_UR, CMP_UR, LD_UR, ST_UR}) begin
            r.has_src_gp = 1'b1;
            r.src_gp     = w[11:8];
        end
        r.gp_we = op inside {MOV_UR, ADD_UR, SUB_UR, LD_UR, MOV_UI, ADD_UI, ADD_SI};
        if (op == LD_UR) begin
            r.has_src_ar = 1'b1;
            r.src_ar     = w[11:10];
        end
        if (op == ST_UR || op == JCC_UR) begin
            r.has_tgt_ar = 1'b1;
            r.tgt_ar     = w[15:14];
        end
        if (op == SRMOV_UR || op == SRLD_SO) begin
            r.sr_we      = 1'b1;
            r.has_src_sr = 1'b1;
            r.tgt_sr     = w[15:14];
            r.src_sr     = w[13:12];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    assign exp_word = prog[id_pc[7:0]];
    assign exp_dec  = ref_decode(exp_word);
    // A word newly loaded into the decode register
    assign fresh    = id_valid && !stall_prev;

    always @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            stall_prev      <= 1'b0;
            discard_pending <= 1'b0;
            seen_ack        <= 1'b0;
            seen_req        <= 1'b0;
            next_pc         <= `FRONT_RESET_PC;
            n_fresh         <= 0;
            n_discard       <= 0;
        end else begin
            stall_prev <= stall;
            seen_ack   <= seen_ack || wb_ack;
            seen_req   <= seen_req || wb_cyc;
            if (fresh) n_fresh <= n_fresh + 1;
            if (flush) begin
                next_pc <= redirect_pc;
            end else if (fresh) begin
                next_pc <= id_pc + 1'b1;
            end
            if (wb_ack) begin
                discard_pending <= 1'b0;
            end else if (flush && wb_cyc) begin
                discard_pending <= 1'b1;
                n_discard       <= n_discard + 1;
            end
        end
    end

    // Reset and bus discipline
    a_reset_quiet: assert property (@(posedge iw_clk)
        $fell(iw_rst) |-> (!wb_cyc && !wb_stb && !id_valid))
        else report_error("bus or id_valid active out of reset");
    a_pre_ack: assert property (@(posedge iw_clk) disable iff (iw_rst)
        !seen_ack |-> !id_valid)
        else report_error("id_valid before the first ack");
    a_first_adr: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (wb_cyc && !seen_req) |-> (wb_adr == `FRONT_RESET_PC))
        else report_mismatch("wb_adr", `FRONT_RESET_PC, $sampled(wb_adr));
    a_stb_cyc: assert property (@(posedge iw_clk) disable iff (iw_rst)
        wb_stb |-> wb_cyc)
        else report_error("wb_stb high without wb_cyc");
    a_no_write: assert property (@(posedge iw_clk) disable iff (iw_rst) !wb_we)
        else report_error("wb_we went high");
    a_adr_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr)))
        else report_error("wb_adr or wb_cyc changed before ack");

    // Decoded bundle against the reference
    a_instr: assert property (@(posedge iw_clk) disable iff (iw_rst)
        id_valid |-> (id_instr == exp_word && id_opc == exp_word[23:16]))
        else report_mismatch("id_instr/id_opc",
                             $sampled({exp_word, exp_word[23:16]}),
                             $sampled({id_instr, id_opc}));
    a_imm: assert property (@(posedge iw_clk) disable iff (iw_rst)
        id_valid |-> ({id_imm_en, id_sgn_en, id_imm_kind} ==
                      {exp_dec.imm_en, exp_dec.sgn_en, exp_dec.kind}))
        else report_mismatch("id_imm_en/id_sgn_en/id_imm_kind",
                             $sampled({exp_dec.imm_en, exp_dec.sgn_en, exp_dec.kind}),
                             $sampled({id_imm_en, id_sgn_en, id_imm_kind}));
    a_imm_val: assert property (@(posedge iw_clk) disable iff (iw_rst)
        id_valid |-> (id_imm_val == exp_dec.imm_val))
        else report_mismatch("id_imm_val", $sampled(exp_dec.imm_val), $sampled(id_imm_val));
    a_cc: assert property (@(posedge iw_clk) disable iff (iw_rst)
        id_valid |-> (id_cc == exp_dec.cc))
        else report_mismatch("id_cc", $sampled(exp_dec.cc), $sampled(id_cc));
    a_gp: assert property (@(posedge iw_clk) disable iff (iw_rst)
        id_valid |-> ({id_has_src_gp, id_src_gp, id_tgt_gp, id_tgt_gp_we} ==
                      {exp_dec.has_src_gp, exp_dec.src_gp, exp_dec.tgt_gp, exp_dec.gp_we}))
        else report_mismatch("id_has_src_gp/id_src_gp/id_tgt_gp/id_tgt_gp_we",
                             $sampled({exp_dec.has_src_gp, exp_dec.src_gp, exp_dec.tgt_gp,
                                       exp_dec.gp_we}),
                             $sampled({id_has_src_gp, id_src_gp, id_tgt_gp, id_tgt_gp_we}));
    a_ar: assert property (@(posedge iw_clk) disable iff (iw_rst)
        id_valid |-> ({id_has_src_ar, id_src_ar, id_has_tgt_ar, id_tgt_ar} ==
                      {exp_dec.has_src_ar, exp_dec.src_ar, exp_dec.has_tgt_ar, exp_dec.tgt_ar}))
        else report_mismatch("id_has_src_ar/id_src_ar/id_has_tgt_ar/id_tgt_ar",
                             $sampled({exp_dec.has_src_ar, exp_dec.src_ar, exp_dec.has_tgt_ar,
                                       exp_dec.tgt_ar}),
                             $sampled({id_has_src_ar, id_src_ar, id_has_tgt_ar, id_tgt_ar}));
    a_sr: assert property (@(posedge iw_clk) disable iff (iw_rst)
        id_valid |-> ({id_has_src_sr, id_src_sr, id_tgt_sr, id_tgt_sr_we} ==
                      {exp_dec.has_src_sr, exp_dec.src_sr, exp_dec.tgt_sr, exp_dec.sr_we}))
        else report_mismatch("id_has_src_sr/id_src_sr/id_tgt_sr/id_tgt_sr_we",
                             $sampled({exp_dec.has_src_sr, exp_dec.src_sr, exp_dec.tgt_sr,
                                       exp_dec.sr_we}),
                             $sampled({id_has_src_sr, id_src_sr, id_tgt_sr, id_tgt_sr_we}));

    // Sequencing, stall and flush
    a_pc_seq: assert property (@(posedge iw_clk) disable iff (iw_rst)
        fresh |-> (id_pc == next_pc))
        else report_mismatch("id_pc", $sampled(next_pc), $sampled(id_pc));
    a_ack_to_valid: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (wb_ack && !discard_pending && !stall && !flush) |=> id_valid)
        else report_error("id_valid did not follow ack by one cycle");
    a_stall_hold: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=> $stable({id_valid, id_pc, id_instr, id_opc, id_imm_en,
                                       id_sgn_en, id_imm_kind, id_imm_val, id_cc,
                                       id_has_src_gp, id_src_gp, id_tgt_gp, id_tgt_gp_we,
                                       id_has_src_ar, id_src_ar, id_has_tgt_ar, id_tgt_ar,
                                       id_has_src_sr, id_src_sr, id_tgt_sr, id_tgt_sr_we}))
        else report_error("id outputs changed during stall");
    a_stall_no_req: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (stall && (!wb_cyc || wb_ack)) |=> !wb_cyc)
        else report_error("new bus request started during stall");
    a_flush_clear: assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush |=> !id_valid)
        else report_error("id_valid high the cycle after flush");

    task automatic run_traffic(input integer target, input integer limit,
                               input logic random_en);
        integer cycles;
        cycles = 0;
        while (n_fresh < target && cycles < limit) begin
            @(negedge iw_clk);
            cycles = cycles + 1;
            if (random_en) begin
                stall = (($random(seed) & 3) == 0);
                flush = (($random(seed) & 15) == 0);
                if (flush) redirect_pc = $random(seed);
            end else begin
                stall = 1'b0;
                flush = 1'b0;
            end
        end
        if (n_fresh < target) report_error("timeout waiting for decoded words");
    endtask

    initial begin
        logic [31:0] w;
        seed        = 32'h82e2;
        iw_rst      = 1'b1;
        flush       = 1'b0;
        stall       = 1'b0;
        redirect_pc = '0;
        opc_list    = '{MOV_UR, ADD_UR, SUB_UR, CMP_UR, LD_UR, ST_UR, MOV_UI, ADD_UI,
                        CMP_UI, ST_UI, ADD_SI, JCC_UR, JCC_UI, BAL_SO, SRMOV_UR, SRLD_SO};
        // Every opcode appears once in each run of sixteen words
        for (int i = 0; i < 256; i++) begin
            w               = $random(seed);
            w[23:16]        = opc_list[i % 16];
            prog[i]         = w[23:0];
            imem0.mem[i]    = w[23:0];
        end
        repeat (10) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;
        run_traffic(40, 400, 1'b0);
        run_traffic(600, 20000, 1'b1);
        run_traffic(n_fresh + 20, 400, 1'b0);
        if (n_discard == 0) begin
            report_error("no flush landed on an outstanding transfer");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch_wb.sv
hw/imm_decode.sv
hw/reg_decode.sv
hw/stg_id.sv
hw/front_end.sv
test/tb_wb_imem.sv
test/tb_front_end.sv

//--- Bender.yml
package:
  name: front_end

sources:
  - include_dirs:
      - hw
    files:
      - hw/isa_pkg.sv
      - hw/pipe_pkg.sv
      - hw/fetch_wb.sv
      - hw/imm_decode.sv
      - hw/reg_decode.sv
      - hw/stg_id.sv
      - hw/front_end.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_wb_imem.sv
      - test/tb_front_end.sv
